//--- include/synth_params.svh
`ifndef SYNTH_PARAMS_SVH
`define SYNTH_PARAMS_SVH

`define AUDIO_WIDTH 12
`define PHASE_WIDTH 24 // Top AUDIO_WIDTH bits form the wave
`define NOTE_WIDTH 7
`define VELOCITY_WIDTH 7
`define ENV_WIDTH 12 // Full scale is all ones
`define RATE_WIDTH 8

`define SEMITONES 12
`define BASE_INC_WIDTH 8

// Octave zero increments, equal temperament scaled to 128 at C
`define BASE_INC_0 8'd128
`define BASE_INC_1 8'd136
`define BASE_INC_2 8'd144
`define BASE_INC_3 8'd152
`define BASE_INC_4 8'd161
`define BASE_INC_5 8'd171
`define BASE_INC_6 8'd181
`define BASE_INC_7 8'd192
`define BASE_INC_8 8'd203
`define BASE_INC_9 8'd215
`define BASE_INC_10 8'd228
`define BASE_INC_11 8'd242

`endif

//--- design/synth_pkg.sv
package synth_pkg;

  typedef enum logic {
    NOTE_OFF,
    NOTE_ON
  } note_status_t;

  typedef enum logic [1:0] {
    WAVE_NONE,
    WAVE_SAW,
    WAVE_PULSE,
    WAVE_TRIANGLE
  } wave_t;

  // Envelope phases of one ADSR cycle
  typedef enum logic [2:0] {
    ENV_IDLE,
    ENV_ATTACK,
    ENV_DECAY,
    ENV_SUSTAIN,
    ENV_RELEASE
  } env_state_t;

endpackage : synth_pkg

//--- design/note_decoder.sv
`timescale 1ns/1ps

`include "synth_params.svh"

module note_decoder (
  input  logic                           clock_50_000_000,
  input  logic                           rst,
  input  logic                           note_strobe,
  input  synth_pkg::note_status_t        note_status,
  input  logic [`NOTE_WIDTH-1:0]         note_number,
  input  logic [`VELOCITY_WIDTH-1:0]     note_velocity,
  output logic [`PHASE_WIDTH-1:0]        phase_inc,
  output logic [`VELOCITY_WIDTH-1:0]     velocity,
  output logic                           gate,
  output logic                           note_start,
  output logic                           note_stop
);

  logic [3:0]                 semitone;
  logic [3:0]                 octave;
  logic [`BASE_INC_WIDTH-1:0] base_inc;
  logic [`NOTE_WIDTH-1:0]     current_note; // Note that owns the gate

  assign semitone = 4'(note_number % `NOTE_WIDTH'(`SEMITONES));
  assign octave   = 4'(note_number / `NOTE_WIDTH'(`SEMITONES));

  always_comb begin
    case (semitone)
      4'd0:    base_inc = `BASE_INC_0;
      4'd1:    base_inc = `BASE_INC_1;
      4'd2:    base_inc = `BASE_INC_2;
      4'd3:    base_inc = `BASE_INC_3;
      4'd4:    base_inc = `BASE_INC_4;
      4'd5:    base_inc = `BASE_INC_5;
      4'd6:    base_inc = `BASE_INC_6;
      4'd7:    base_inc = `BASE_INC_7;
      4'd8:    base_inc = `BASE_INC_8;
      4'd9:    base_inc = `BASE_INC_9;
      4'd10:   base_inc = `BASE_INC_10;
      4'd11:   base_inc = `BASE_INC_11;
      default: base_inc = '0;
    endcase
  end

  always_ff @(posedge clock_50_000_000) begin
    if (rst) begin
      phase_inc    <= '0;
      velocity     <= '0;
      gate         <= 1'b0;
      note_start   <= 1'b0;
      note_stop    <= 1'b0;
      current_note <= '0;
    end else begin
      note_start <= 1'b0;
      note_stop  <= 1'b0;
      if (note_strobe && note_status == synth_pkg::NOTE_ON) begin
        phase_inc    <= `PHASE_WIDTH'(base_inc) << octave; // Octave doubles the rate
        velocity     <= note_velocity;
        gate         <= 1'b1;
        note_start   <= 1'b1;
        current_note <= note_number;
      end else if (note_strobe && gate && note_number == current_note) begin
        gate      <= 1'b0; // Only the sounding note may end it
        note_stop <= 1'b1;
      end
    end
  end

  a_start_stop_exclusive : assert property (
    @(posedge clock_50_000_000) disable iff (rst) !(note_start && note_stop)
  );

endmodule : note_decoder

//--- design/oscillator.sv
`timescale 1ns/1ps

`include "synth_params.svh"

module oscillator (
  input  logic                    clock_50_000_000,
  input  logic                    rst,
  input  logic                    note_start,
  input  logic [`PHASE_WIDTH-1:0] phase_inc,
  input  logic [`AUDIO_WIDTH-1:0] duty,
  output logic [`AUDIO_WIDTH-1:0] saw,
  output logic [`AUDIO_WIDTH-1:0] pulse,
  output logic [`AUDIO_WIDTH-1:0] triangle
);

  logic [`PHASE_WIDTH-1:0] phase;
  logic [`AUDIO_WIDTH-1:0] p;
  logic [`AUDIO_WIDTH-1:0] p_twice;

  assign p       = phase[`PHASE_WIDTH-1 -: `AUDIO_WIDTH];
  assign p_twice = {p[`AUDIO_WIDTH-2:0], 1'b0};

  // Accumulator wraps freely
  always_ff @(posedge clock_50_000_000) begin
    if (rst) begin
      phase <= '0;
    end else if (note_start) begin
      phase <= '0; // Each new note starts at phase zero
    end else begin
      phase <= phase + phase_inc;
    end
  end

  always_ff @(posedge clock_50_000_000) begin
    saw <= p;

    if (p < duty) begin
      pulse <= '1;
    end else begin
      pulse <= '0;
    end

    if (p[`AUDIO_WIDTH-1]) begin
      triangle <= ~p_twice; // Falling half
    end else begin
      triangle <= p_twice;
    end
  end

endmodule : oscillator

//--- design/envelope_generator.sv
`timescale 1ns/1ps

`include "synth_params.svh"

module envelope_generator (
  input  logic                   clock_50_000_000,
  input  logic                   rst,
  input  logic                   note_start,
  input  logic                   note_stop,
  input  logic [`RATE_WIDTH-1:0] attack_rate,
  input  logic [`RATE_WIDTH-1:0] decay_rate,
  input  logic [`RATE_WIDTH-1:0] release_rate,
  input  logic [`ENV_WIDTH-1:0]  sustain_level,
  output logic [`ENV_WIDTH-1:0]  level,
  output logic                   active
);

  synth_pkg::env_state_t state;

  logic [`ENV_WIDTH:0] attack_sum;
  logic [`ENV_WIDTH:0] decay_diff;
  logic [`ENV_WIDTH:0] release_diff;

  // One extra bit catches overflow and underflow
  assign attack_sum   = {1'b0, level} + (`ENV_WIDTH+1)'(attack_rate);
  assign decay_diff   = {1'b0, level} - (`ENV_WIDTH+1)'(decay_rate);
  assign release_diff = {1'b0, level} - (`ENV_WIDTH+1)'(release_rate);

  always_ff @(posedge clock_50_000_000) begin
    if (rst) begin
      state  <= synth_pkg::ENV_IDLE;
      level  <= '0;
      active <= 1'b0;
    end else if (note_start) begin
      state  <= synth_pkg::ENV_ATTACK; // Level carries over for a smooth retrigger
      active <= 1'b1;
    end else if (note_stop && state != synth_pkg::ENV_IDLE) begin
      state <= synth_pkg::ENV_RELEASE;
    end else begin
      case (state)
        synth_pkg::ENV_ATTACK: begin
          if (attack_sum[`ENV_WIDTH]) begin
            level <= '1;
            state <= synth_pkg::ENV_DECAY;
          end else begin
            level <= attack_sum[`ENV_WIDTH-1:0];
          end
        end
        synth_pkg::ENV_DECAY: begin
          if (decay_diff[`ENV_WIDTH] || decay_diff[`ENV_WIDTH-1:0] <= sustain_level) begin
            level <= sustain_level;
            state <= synth_pkg::ENV_SUSTAIN;
          end else begin
            level <= decay_diff[`ENV_WIDTH-1:0];
          end
        end
        synth_pkg::ENV_RELEASE: begin
          if (release_diff[`ENV_WIDTH] || release_diff[`ENV_WIDTH-1:0] == '0) begin
            level  <= '0;
            state  <= synth_pkg::ENV_IDLE;
            active <= 1'b0;
          end else begin
            level <= release_diff[`ENV_WIDTH-1:0];
          end
        end
        default: begin
          level <= level; // Sustain and idle hold
        end
      endcase
    end
  end

  a_sustain_bounded : assert property (
    @(posedge clock_50_000_000) disable iff (rst)
      state == synth_pkg::ENV_SUSTAIN |-> level <= sustain_level
  );

  a_active_matches_state : assert property (
    @(posedge clock_50_000_000) disable iff (rst) active == (state != synth_pkg::ENV_IDLE)
  );

endmodule : envelope_generator

//--- design/voice_mixer.sv
`timescale 1ns/1ps

`include "synth_params.svh"

module voice_mixer (
  input  logic                       clock_50_000_000,
  input  logic                       rst,
  input  synth_pkg::wave_t           wave,
  input  logic [`AUDIO_WIDTH-1:0]    saw,
  input  logic [`AUDIO_WIDTH-1:0]    pulse,
  input  logic [`AUDIO_WIDTH-1:0]    triangle,
  input  logic [`AUDIO_WIDTH-1:0]    level,
  input  logic [`VELOCITY_WIDTH-1:0] velocity,
  output logic [`AUDIO_WIDTH-1:0]    audio
);

  logic [`AUDIO_WIDTH-1:0]                 wave_sample;
  logic [`AUDIO_WIDTH-1:0]                 env_sample;
  logic [2*`AUDIO_WIDTH-1:0]               env_product;
  logic [`AUDIO_WIDTH+`VELOCITY_WIDTH-1:0] vel_product;

  assign env_product = wave_sample * level;
  assign vel_product = env_sample * velocity;

  always_ff @(posedge clock_50_000_000) begin
    if (rst) begin
      wave_sample <= '0;
      env_sample  <= '0;
      audio       <= '0;
    end else begin
      case (wave)
        synth_pkg::WAVE_SAW:      wave_sample <= saw;
        synth_pkg::WAVE_PULSE:    wave_sample <= pulse;
        synth_pkg::WAVE_TRIANGLE: wave_sample <= triangle;
        default:                  wave_sample <= '0; // Muted voice
      endcase
      env_sample <= env_product[2*`AUDIO_WIDTH-1:`AUDIO_WIDTH];
      audio      <= vel_product[`AUDIO_WIDTH+`VELOCITY_WIDTH-1:`VELOCITY_WIDTH];
    end
  end

endmodule : voice_mixer

//--- design/synth_voice.sv
`timescale 1ns/1ps

`include "synth_params.svh"

module synth_voice (
  input  logic                       clock_50_000_000,
  input  logic                       rst,
  input  logic                       note_strobe,
  input  synth_pkg::note_status_t    note_status,
  input  logic [`NOTE_WIDTH-1:0]     note_number,
  input  logic [`VELOCITY_WIDTH-1:0] note_velocity,
  input  synth_pkg::wave_t           wave,
  input  logic [`AUDIO_WIDTH-1:0]    duty,
  input  logic [`RATE_WIDTH-1:0]     attack_rate,
  input  logic [`RATE_WIDTH-1:0]     decay_rate,
  input  logic [`ENV_WIDTH-1:0]      sustain_level,
  input  logic [`RATE_WIDTH-1:0]     release_rate,
  output logic [`AUDIO_WIDTH-1:0]    audio,
  output logic                       voice_active
);

  logic [`PHASE_WIDTH-1:0]    phase_inc;
  logic [`VELOCITY_WIDTH-1:0] velocity;
  logic                       gate;
  logic                       note_start;
  logic                       note_stop;
  logic [`AUDIO_WIDTH-1:0]    saw;
  logic [`AUDIO_WIDTH-1:0]    pulse;
  logic [`AUDIO_WIDTH-1:0]    triangle;
  logic [`ENV_WIDTH-1:0]      level;

  note_decoder i_note_decoder (
    .clock_50_000_000, .rst, .note_strobe, .note_status, .note_number, .note_velocity,
    .phase_inc, .velocity, .gate, .note_start, .note_stop
  );

  oscillator i_oscillator (
    .clock_50_000_000, .rst, .note_start, .phase_inc, .duty, .saw, .pulse, .triangle
  );

  envelope_generator i_envelope_generator (
    .clock_50_000_000, .rst, .note_start, .note_stop, .attack_rate, .decay_rate,
    .release_rate, .sustain_level, .level, .active(voice_active)
  );

  voice_mixer i_voice_mixer (
    .clock_50_000_000, .rst, .wave, .saw, .pulse, .triangle, .level, .velocity, .audio
  );

  // The gate is only a status, the envelope follows the start and stop pulses
  a_gate_tracks_envelope : assert property (
    @(posedge clock_50_000_000) disable iff (rst) gate |=> voice_active
  );

endmodule : synth_voice

//--- testbench/synth_voice_tb.sv
`timescale 1ns/1ps

`include "synth_params.svh"

module synth_voice_tb;

  localparam int N_RANDOM = 40;
  localparam int HOLD_BASE = 16;
  localparam int NOTE_CYCLES = 2 * (HOLD_BASE + 64 + 2); // Note on and optional note off
  localparam int ENV_MAX = (1 << `ENV_WIDTH) - 1;
  localparam int ENV_SPAN = 3 * ((1 << `ENV_WIDTH) / 16) + 16; // All rates are at least 16
  localparam int TEST_CYCLES = 20 + N_RANDOM * NOTE_CYCLES + 8 * ENV_SPAN + 300;
  localparam int TIMEOUT_CYCLES = TEST_CYCLES + 500;

  logic                       clock_50_000_000 = 1'b0;
  logic                       rst;
  logic                       note_strobe;
  synth_pkg::note_status_t    note_status;
  logic [`NOTE_WIDTH-1:0]     note_number;
  logic [`VELOCITY_WIDTH-1:0] note_velocity;
  synth_pkg::wave_t           wave;
  logic [`AUDIO_WIDTH-1:0]    duty;
  logic [`RATE_WIDTH-1:0]     attack_rate;
  logic [`RATE_WIDTH-1:0]     decay_rate;
  logic [`ENV_WIDTH-1:0]      sustain_level;
  logic [`RATE_WIDTH-1:0]     release_rate;
  logic [`AUDIO_WIDTH-1:0]    audio;
  logic                       voice_active;

  logic [15:0] lfsr = 16'd45121;
  int          error_count = 0;
  int          cycle_count = 0;

  // Cycle model state
  logic                       m_start = 1'b0;
  logic                       m_stop = 1'b0;
  logic                       m_gate = 1'b0;
  logic [`PHASE_WIDTH-1:0]    m_inc = '0;
  logic [`VELOCITY_WIDTH-1:0] m_vel = '0;
  logic [`NOTE_WIDTH-1:0]     m_cur = '0;
  logic [`PHASE_WIDTH-1:0]    m_phase = '0;
  logic [`AUDIO_WIDTH-1:0]    m_saw = '0;
  logic [`AUDIO_WIDTH-1:0]    m_pulse = '0;
  logic [`AUDIO_WIDTH-1:0]    m_tri = '0;
  synth_pkg::env_state_t      m_state = synth_pkg::ENV_IDLE;
  logic [`ENV_WIDTH-1:0]      m_level = '0;
  logic                       m_active = 1'b0;
  logic [`AUDIO_WIDTH-1:0]    m_s1 = '0;
  logic [`AUDIO_WIDTH-1:0]    m_s2 = '0;
  logic [`AUDIO_WIDTH-1:0]    m_audio = '0;

  wire                        ev_on = note_strobe && note_status == synth_pkg::NOTE_ON;
  wire                        ev_off = note_strobe && !ev_on && m_gate && note_number == m_cur;
  wire [`AUDIO_WIDTH-1:0]     m_p = m_phase[`PHASE_WIDTH-1 -: `AUDIO_WIDTH];
  wire [`AUDIO_WIDTH-1:0]     m_p_twice = m_p << 1;

  synth_voice i_synth_voice (
    .clock_50_000_000, .rst, .note_strobe, .note_status, .note_number, .note_velocity,
    .wave, .duty, .attack_rate, .decay_rate, .sustain_level, .release_rate,
    .audio, .voice_active
  );

  always #10 clock_50_000_000 = ~clock_50_000_000;

  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]}; // x^16 + x^14 + x^13 + x^11 + 1
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      r = {r[30:0], lfsr[0]};
    end
    return r;
  endfunction

  function automatic logic [`PHASE_WIDTH-1:0] note_increment(input logic [`NOTE_WIDTH-1:0] n);
    logic [`BASE_INC_WIDTH-1:0] base_table [12];
    base_table = '{`BASE_INC_0, `BASE_INC_1, `BASE_INC_2, `BASE_INC_3, `BASE_INC_4,
                   `BASE_INC_5, `BASE_INC_6, `BASE_INC_7, `BASE_INC_8, `BASE_INC_9,
                   `BASE_INC_10, `BASE_INC_11};
    return `PHASE_WIDTH'(base_table[int'(n) % 12]) << (int'(n) / 12);
  endfunction

  function automatic logic [`AUDIO_WIDTH-1:0] pick_wave(input synth_pkg::wave_t w,
      input logic [`AUDIO_WIDTH-1:0] s, input logic [`AUDIO_WIDTH-1:0] pl,
      input logic [`AUDIO_WIDTH-1:0] tr);
    case (w)
      synth_pkg::WAVE_SAW:      return s;
      synth_pkg::WAVE_PULSE:    return pl;
      synth_pkg::WAVE_TRIANGLE: return tr;
      default:                  return '0;
    endcase
  endfunction

  // Model registers sample the same pre-edge inputs as the DUT
  always @(posedge clock_50_000_000) begin
    m_saw   <= m_p;
    m_pulse <= (m_p < duty) ? '1 : '0;
    m_tri   <= m_p[`AUDIO_WIDTH-1] ? ~m_p_twice : m_p_twice;
    if (rst) begin
      m_start  <= 1'b0;
      m_stop   <= 1'b0;
      m_gate   <= 1'b0;
      m_inc    <= '0;
      m_vel    <= '0;
      m_cur    <= '0;
      m_phase  <= '0;
      m_state  <= synth_pkg::ENV_IDLE;
      m_level  <= '0;
      m_active <= 1'b0;
      m_s1     <= '0;
      m_s2     <= '0;
      m_audio  <= '0;
    end else begin
      m_start <= ev_on;
      m_stop  <= ev_off;
      if (ev_on) begin
        m_inc  <= note_increment(note_number);
        m_vel  <= note_velocity;
        m_gate <= 1'b1;
        m_cur  <= note_number;
      end else if (ev_off) begin
        m_gate <= 1'b0;
      end
      m_phase <= m_start ? '0 : m_phase + m_inc;
      if (m_start) begin
        m_state  <= synth_pkg::ENV_ATTACK;
        m_active <= 1'b1;
      end else if (m_stop && m_state != synth_pkg::ENV_IDLE) begin
        m_state <= synth_pkg::ENV_RELEASE;
      end else if (m_state == synth_pkg::ENV_ATTACK) begin
        if (int'(m_level) + int'(attack_rate) > ENV_MAX) begin
          m_level <= '1;
          m_state <= synth_pkg::ENV_DECAY;
        end else begin
          m_level <= m_level + `ENV_WIDTH'(attack_rate);
        end
      end else if (m_state == synth_pkg::ENV_DECAY) begin
        if (int'(m_level) - int'(decay_rate) <= int'(sustain_level)) begin
          m_level <= sustain_level;
          m_state <= synth_pkg::ENV_SUSTAIN;
        end else begin
          m_level <= m_level - `ENV_WIDTH'(decay_rate);
        end
      end else if (m_state == synth_pkg::ENV_RELEASE) begin
        if (int'(m_level) - int'(release_rate) <= 0) begin
          m_level  <= '0;
          m_state  <= synth_pkg::ENV_IDLE;
          m_active <= 1'b0;
        end else begin
          m_level <= m_level - `ENV_WIDTH'(release_rate);
        end
      end
      m_s1    <= pick_wave(wave, m_saw, m_pulse, m_tri);
      m_s2    <= `AUDIO_WIDTH'((int'(m_s1) * int'(m_level)) >> `AUDIO_WIDTH);
      m_audio <= `AUDIO_WIDTH'((int'(m_s2) * int'(m_vel)) >> `VELOCITY_WIDTH);
    end
  end

  // Outputs are settled at the falling edge
  always @(negedge clock_50_000_000) begin
    if (!rst) begin
      assert (audio === m_audio) else begin
        error_count++;
        $display("mismatch at %0t: audio %0d, expected %0d", $time, audio, m_audio);
      end
      assert (voice_active === m_active) else begin
        error_count++;
        $display("mismatch at %0t: voice_active %0b, expected %0b", $time, voice_active,
                 m_active);
      end
      assert (i_synth_voice.note_start === m_start) else begin
        error_count++;
        $display("mismatch at %0t: note_start %0b, expected %0b", $time,
                 i_synth_voice.note_start, m_start);
      end
    end
  end

  always @(posedge clock_50_000_000) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("timeout: the run did not finish within %0d cycles, errors: %0d",
               TIMEOUT_CYCLES, error_count);
      $display("*** FAILED ***");
      $finish;
    end
  end

  task automatic drive_event(input synth_pkg::note_status_t status,
                             input logic [`NOTE_WIDTH-1:0] number,
                             input logic [`VELOCITY_WIDTH-1:0] vel);
    @(posedge clock_50_000_000);
    note_strobe   <= 1'b1;
    note_status   <= status;
    note_number   <= number;
    note_velocity <= vel;
  endtask

  task automatic end_strobe();
    @(posedge clock_50_000_000);
    note_strobe <= 1'b0;
  endtask

  task automatic hold(input int cycles);
    repeat (cycles) @(posedge clock_50_000_000);
  endtask

  task automatic wait_inactive();
    int waited;
    waited = 0;
    @(negedge clock_50_000_000);
    while (voice_active && waited < ENV_SPAN) begin
      @(negedge clock_50_000_000);
      waited++;
    end
    assert (!voice_active) else begin
      error_count++;
      $display("voice still active %0d cycles after the note ended, at %0t", waited, $time);
    end
  endtask

  task automatic wait_sustain();
    int waited;
    waited = 0;
    @(negedge clock_50_000_000);
    while (m_state != synth_pkg::ENV_SUSTAIN && waited < ENV_SPAN) begin
      @(negedge clock_50_000_000);
      waited++;
    end
    assert (m_state == synth_pkg::ENV_SUSTAIN) else begin
      error_count++;
      $display("envelope never reached sustain within %0d cycles, at %0t", waited, $time);
    end
  endtask

  task automatic check_silent_active();
    @(negedge clock_50_000_000);
    assert (audio == '0 && voice_active) else begin
      error_count++;
      $display("mismatch at %0t: muted voice gave audio %0d, active %0b", $time, audio,
               voice_active);
    end
  endtask

  initial begin
    logic [`NOTE_WIDTH-1:0] number;
    rst           = 1'b1;
    note_strobe   = 1'b0;
    note_status   = synth_pkg::NOTE_OFF;
    note_number   = '0;
    note_velocity = '0;
    wave          = synth_pkg::WAVE_SAW;
    duty          = 12'h800;
    attack_rate   = 8'h40;
    decay_rate    = 8'h20;
    sustain_level = 12'h900;
    release_rate  = 8'h30;
    repeat (2) @(posedge clock_50_000_000);
    rst <= 1'b0;

    repeat (20) begin
      @(negedge clock_50_000_000);
      assert (audio == '0 && !voice_active) else begin
        error_count++;
        $display("mismatch at %0t: voice not silent after reset", $time);
      end
    end

    // Random notes, sustain stays fixed so it never drops below a held level
    for (int i = 0; i < N_RANDOM; i++) begin
      number = `NOTE_WIDTH'(rand_bits(`NOTE_WIDTH));
      drive_event(synth_pkg::NOTE_ON, number, `VELOCITY_WIDTH'(rand_bits(`VELOCITY_WIDTH)));
      wave         <= synth_pkg::wave_t'(2'(rand_bits(2)));
      duty         <= `AUDIO_WIDTH'(rand_bits(`AUDIO_WIDTH));
      attack_rate  <= `RATE_WIDTH'(rand_bits(`RATE_WIDTH)) | 8'h10;
      decay_rate   <= `RATE_WIDTH'(rand_bits(`RATE_WIDTH)) | 8'h10;
      release_rate <= `RATE_WIDTH'(rand_bits(`RATE_WIDTH)) | 8'h10;
      end_strobe();
      hold(HOLD_BASE + int'(rand_bits(6)));
      if (rand_bits(1) == 32'd1) begin
        drive_event(synth_pkg::NOTE_OFF, number, '0);
        end_strobe();
        hold(HOLD_BASE + int'(rand_bits(6)));
      end
    end

    // The last random note may still be held
    drive_event(synth_pkg::NOTE_OFF, number, '0);
    end_strobe();
    wait_inactive();
    @(posedge clock_50_000_000);
    wave <= synth_pkg::WAVE_NONE;
    drive_event(synth_pkg::NOTE_ON, 7'd69, 7'd100);
    end_strobe();
    hold(40);
    check_silent_active();
    drive_event(synth_pkg::NOTE_ON, 7'd72, 7'd0);
    wave <= synth_pkg::WAVE_TRIANGLE;
    end_strobe();
    hold(40);
    check_silent_active();
    drive_event(synth_pkg::NOTE_OFF, 7'd72, '0);
    end_strobe();
    wait_inactive();

    // Full ADSR cycle, settings change only while idle
    @(posedge clock_50_000_000);
    sustain_level <= `ENV_WIDTH'(rand_bits(`ENV_WIDTH));
    attack_rate   <= `RATE_WIDTH'(rand_bits(`RATE_WIDTH)) | 8'h10;
    decay_rate    <= `RATE_WIDTH'(rand_bits(`RATE_WIDTH)) | 8'h10;
    release_rate  <= `RATE_WIDTH'(rand_bits(`RATE_WIDTH)) | 8'h10;
    wave          <= synth_pkg::WAVE_SAW;
    drive_event(synth_pkg::NOTE_ON, 7'd60, 7'd127);
    end_strobe();
    wait_sustain();
    hold(30);
    drive_event(synth_pkg::NOTE_OFF, 7'd60, '0);
    end_strobe();
    wait_inactive();

    @(posedge clock_50_000_000);
    sustain_level <= 12'hc00;
    attack_rate   <= 8'h80;
    decay_rate    <= 8'h40;
    release_rate  <= 8'h10; // Long release so the retrigger lands mid release
    wave          <= synth_pkg::WAVE_PULSE;
    drive_event(synth_pkg::NOTE_ON, 7'd60, 7'd90);
    end_strobe();
    hold(80);
    drive_event(synth_pkg::NOTE_OFF, 7'd61, '0);
    end_strobe();
    hold(20);
    @(negedge clock_50_000_000);
    assert (voice_active) else begin
      error_count++;
      $display("voice stopped by a note off for another note, at %0t", $time);
    end
    drive_event(synth_pkg::NOTE_OFF, 7'd60, '0);
    end_strobe();
    hold(20);
    drive_event(synth_pkg::NOTE_ON, 7'd64, 7'd90);
    end_strobe();
    hold(60);
    drive_event(synth_pkg::NOTE_OFF, 7'd64, '0);
    end_strobe();
    wait_inactive();

    drive_event(synth_pkg::NOTE_ON, 7'd50, 7'd70);
    drive_event(synth_pkg::NOTE_ON, 7'd55, 7'd80);
    drive_event(synth_pkg::NOTE_OFF, 7'd55, '0);
    drive_event(synth_pkg::NOTE_ON, 7'd70, 7'd110);
    end_strobe();
    hold(40);
    drive_event(synth_pkg::NOTE_ON, 7'd40, 7'd60);
    drive_event(synth_pkg::NOTE_OFF, 7'd40, '0);
    end_strobe();
    wait_inactive();
    hold(5);

    $display("run complete after %0d cycles, errors: %0d", cycle_count, error_count);
    if (error_count == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule : synth_voice_tb

//--- src.f
+incdir+include
design/synth_pkg.sv
design/note_decoder.sv
design/oscillator.sv
design/envelope_generator.sv
design/voice_mixer.sv
design/synth_voice.sv
testbench/synth_voice_tb.sv

//--- run_sim.sh
#!/bin/sh
# Builds the synth voice testbench with Verilator, runs it and scans the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f src.f \
  --top-module synth_voice_tb -o synth_voice_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/synth_voice_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q '\*\*\* FAILED \*\*\*' "$LOG"; then
  echo "simulation reported failure"
  exit 1
fi

exit 0
